// ==== sources.f ====
+incdir+hdl
hdl/mem_stage_pkg.sv
hdl/store_align.sv
hdl/load_align.sv
hdl/data_ram.sv
hdl/mem_ctrl.sv
hdl/mem_stage_top.sv
verification/mem_stage_asserts.sv
verification/mem_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
CFLAGS_EXTRA ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(CFLAGS_EXTRA) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/mem_stage_tb.sv ====
`include "mem_stage_defines.svh"

module mem_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mem_stage_pkg::*;

    localparam int MEM_BYTES   = 4 * (2 ** `MEM_RAM_AW);
    localparam int RESET_REQS  = 2;
    localparam int WORD_REQS   = 16;
    localparam int LANE_REQS   = 13;
    localparam int EXT_REQS    = 52;
    localparam int ALIGN_REQS  = 6;
    localparam int RANDOM_REQS = 16 + 300;
    localparam int TOTAL_REQS  = RESET_REQS + WORD_REQS + LANE_REQS + EXT_REQS +
                                 ALIGN_REQS + RANDOM_REQS;
    localparam int TIMEOUT_NS  = (TOTAL_REQS + 16) * 10 + 200 * 10;

    logic        clk;
    logic        arst_n;
    logic        req;
    logic        is_store;
    logic [2:0]  funct3;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        resp;
    logic        fault;
    logic [31:0] rdata;

    logic [7:0]  ref_mem [MEM_BYTES];                // Byte-wide reference memory.
    logic [32:0] exp_q [$];                          // Expected {fault, rdata} per request.
    logic [31:0] addr_q [$];
    int          errors;
    int          checks;
    int          test_errors;
    int          test_checks;
    string       test_name;

    mem_stage_top UUT
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .is_store (is_store),
        .funct3   (funct3),
        .addr     (addr),
        .wdata    (wdata),
        .resp     (resp),
        .fault    (fault),
        .rdata    (rdata)
    );

    always #5 clk = ~clk;

    // Applies one access to the reference memory and returns the expected response.
    task automatic model_access(input logic st, input logic [2:0] f3, input logic [31:0] a,
                                input logic [31:0] wd, output logic [32:0] expect_rsp);
        logic        known;
        logic        mis;
        logic [1:0]  sz;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] data;
        int          base;
        int          off;
        known = st ? (f3 <= 3'd2) : (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
        sz    = f3[1:0];
        mis   = ((sz == 2'd1) && a[0]) || ((sz == 2'd2) && (a[1:0] != 2'b00));
        base  = int'(a[`MEM_RAM_AW+1:2]) * 4;        // High address bits alias.
        off   = int'(a[1:0]);
        data  = '0;
        if (known && !mis)
        begin
            if (st)
            begin
                ref_mem[base+off] = wd[7:0];
                if (sz != 2'd0)
                    ref_mem[base+off+1] = wd[15:8];
                if (sz == 2'd2)
                begin
                    ref_mem[base+2] = wd[23:16];
                    ref_mem[base+3] = wd[31:24];
                end
            end
            else if (sz == 2'd0)
            begin
                b    = ref_mem[base+off];
                data = f3[2] ? {24'b0, b} : {{24{b[7]}}, b};
            end
            else if (sz == 2'd1)
            begin
                h    = {ref_mem[base+off+1], ref_mem[base+off]};
                data = f3[2] ? {16'b0, h} : {{16{h[15]}}, h};
            end
            else
                data = {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
        end
        expect_rsp = {!(known && !mis), data};
    endtask

    task automatic issue(input logic st, input logic [2:0] f3, input logic [31:0] a,
                         input logic [31:0] wd);
        logic [32:0] expect_rsp;
        @(posedge clk);
        #1;
        req      = 1'b1;
        is_store = st;
        funct3   = f3;
        addr     = a;
        wdata    = wd;
        model_access(st, f3, a, wd, expect_rsp);
        exp_q.push_back(expect_rsp);
        addr_q.push_back(a);
    endtask

    // Ends the burst and waits until every response has been checked.
    task automatic drain;
        @(posedge clk);
        #1;
        req = 1'b0;
        while (exp_q.size() > 0)
            @(negedge clk);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
        test_checks = checks;
    endtask

    task automatic finish_test;
        drain();
        $display("Test %s finished: %0d checks, %0d errors", test_name,
                 checks - test_checks, errors - test_errors);
    endtask

    // Responses are compared at the falling edge, where they are stable.
    always @(negedge clk)
    begin
        logic [32:0] expect_rsp;
        logic [31:0] a;
        if (resp)
        begin
            if (exp_q.size() == 0)
            begin
                $display("A response arrived at %0t with no request outstanding", $time);
                errors++;
            end
            else
            begin
                expect_rsp = exp_q.pop_front();
                a          = addr_q.pop_front();
                checks++;
                assert ({fault, rdata} == expect_rsp)
                else
                begin
                    $display("** Error [%0t] addr %h: got fault %b rdata %h, expected %b %h",
                             $time, a, fault, rdata, expect_rsp[32], expect_rsp[31:0]);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        #(TIMEOUT_NS * 1ns);
        $display("The run timed out at %0t before all tests completed", $time);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        logic [31:0] a;
        logic [31:0] d;
        clk      = 1'b0;
        arst_n   = 1'b0;
        req      = 1'b0;
        is_store = 1'b0;
        funct3   = '0;
        addr     = '0;
        wdata    = '0;
        errors   = 0;
        checks   = 0;
        void'($urandom(62255));

        start_test("reset");
        repeat (16)
        begin
            @(negedge clk);
            checks++;
            assert (!resp && !fault)
            else
            begin
                $display("** Error [%0t] resp or fault high during reset", $time);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        checks++;
        assert (!resp && !fault)
        else
        begin
            $display("** Error [%0t] resp or fault high right after reset", $time);
            errors++;
        end
        issue(1'b1, sw, 32'h0, 32'h1234_5678);
        issue(1'b0, lw, 32'h0, 32'h0);
        finish_test();

        start_test("word_round_trip");
        for (int i = 0; i < 8; i++)
        begin
            a = $urandom & 32'hFFFF_FFFC;
            issue(1'b1, sw, a, $urandom);
            issue(1'b0, lw, a, 32'h0);
        end
        finish_test();

        start_test("byte_half_store");
        a = $urandom & 32'hFFFF_FFFC;
        issue(1'b1, sw, a, 32'hA5A5_5A5A);
        for (int o = 0; o < 4; o++)
        begin
            issue(1'b1, sb, a + 32'(o), $urandom);
            issue(1'b0, lw, a, 32'h0);               // Each byte store shows its own lane.
        end
        issue(1'b1, sh, a, $urandom);
        issue(1'b0, lw, a, 32'h0);
        issue(1'b1, sh, a + 32'd2, $urandom);
        issue(1'b0, lw, a, 32'h0);
        finish_test();

        start_test("load_extension");
        for (int w = 0; w < 4; w++)
        begin
            a = $urandom & 32'hFFFF_FFFC;
            d = $urandom | 32'h8080_8080;            // Every byte has its top bit set.
            issue(1'b1, sw, a, d);
            for (int o = 0; o < 4; o++)
            begin
                issue(1'b0, lb, a + 32'(o), 32'h0);
                issue(1'b0, lbu, a + 32'(o), 32'h0);
            end
            for (int o = 0; o < 4; o += 2)
            begin
                issue(1'b0, lh, a + 32'(o), 32'h0);
                issue(1'b0, lhu, a + 32'(o), 32'h0);
            end
        end
        finish_test();

        start_test("misalignment");
        a = $urandom & 32'hFFFF_FFFC;
        issue(1'b1, sw, a, 32'hCAFE_F00D);
        issue(1'b1, sh, a + 32'd1, 32'hFFFF_FFFF);
        issue(1'b0, lh, a + 32'd3, 32'h0);
        issue(1'b1, sw, a + 32'd2, 32'h0000_0000);
        issue(1'b0, lw, a + 32'd1, 32'h0);
        issue(1'b0, lw, a, 32'h0);
        finish_test();

        start_test("random_mix");
        for (int w = 0; w < 16; w++)
            issue(1'b1, sw, 32'(w * 4), $urandom);
        for (int i = 0; i < 300; i++)
        begin
            a = {$urandom} & 32'h0000_003F;          // Stay in the initialised words.
            if ($urandom % 4 == 0)
                a = a | ($urandom << (`MEM_RAM_AW + 2));   // Bits above the index alias.
            issue(1'($urandom), 3'($urandom), a, $urandom);
        end
        finish_test();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule : mem_stage_tb

// ==== verification/mem_stage_asserts.sv ====
module mem_stage_asserts
(
    input logic        clk,
    input logic        arst_n,
    input logic        req,
    input logic        is_store,
    input logic [2:0]  funct3,
    input logic [31:0] addr,
    input logic        ram_we,
    input logic        resp,
    input logic        fault,
    input logic [31:0] rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    logic store_ok;                                  // Store that must not fault.

    assign store_ok = is_store && (funct3 <= 3'd2) &&
                      !((funct3[1:0] == 2'd1) && addr[0]) &&
                      !((funct3[1:0] == 2'd2) && (addr[1:0] != 2'b00));

    resp_after_req: assert property (@(posedge clk) disable iff (!arst_n) req |=> resp)
        else $error("resp missing one cycle after req");

    resp_needs_req: assert property (@(posedge clk) disable iff (!arst_n) resp |-> $past(req))
        else $error("resp without a request in the previous cycle");

    no_write_on_fault: assert property (@(posedge clk) disable iff (!arst_n) ram_we |-> store_ok)
        else $error("RAM write for a faulting request");

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> (!resp && !fault && rdata == '0))
        else $error("outputs not zero during reset");

    lb_sign: assert property (@(posedge clk) disable iff (!arst_n)
                              (req && !is_store && funct3 == 3'd0) |=>
                              (rdata[31:8] == {24{rdata[7]}}))
        else $error("lb result not sign-extended");

    lh_sign: assert property (@(posedge clk) disable iff (!arst_n)
                              (req && !is_store && funct3 == 3'd1) |=>
                              (rdata[31:16] == {16{rdata[15]}}))
        else $error("lh result not sign-extended");

endmodule : mem_stage_asserts

bind mem_stage_top mem_stage_asserts u_mem_stage_asserts
(
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .is_store (is_store),
    .funct3   (funct3),
    .addr     (addr),
    .ram_we   (ram_we),
    .resp     (resp),
    .fault    (fault),
    .rdata    (rdata)
);

// ==== hdl/mem_stage_top.sv ====
`include "mem_stage_defines.svh"

module mem_stage_top
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req,
    input  logic                   is_store,
    input  logic [2:0]             funct3,
    input  logic [`MEM_ADDR_W-1:0] addr,
    input  logic [`MEM_XLEN-1:0]   wdata,
    output logic                   resp,
    output logic                   fault,
    output logic [`MEM_XLEN-1:0]   rdata
);

    import mem_stage_pkg::*;

    access_size_t            size;                   // Size of the request in flight.
    logic [1:0]              offset;
    logic                    ram_we;
    logic [`MEM_RAM_AW-1:0]  index;
    access_size_t            rsp_size;               // Size of the request being answered.
    logic [1:0]              rsp_offset;
    logic                    rsp_signed;
    logic [`MEM_XLEN-1:0]    lane_data;
    logic [`MEM_LANES-1:0]   byte_en;
    logic [`MEM_XLEN-1:0]    ram_rdata;
    logic [`MEM_XLEN-1:0]    load_data;

    mem_ctrl u_mem_ctrl
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .is_store   (is_store),
        .funct3     (funct3),
        .addr       (addr),
        .size       (size),
        .offset     (offset),
        .ram_we     (ram_we),
        .index      (index),
        .rsp_size   (rsp_size),
        .rsp_offset (rsp_offset),
        .rsp_signed (rsp_signed),
        .load_data  (load_data),
        .resp       (resp),
        .fault      (fault),
        .rdata      (rdata)
    );

    store_align u_store_align
    (
        .size      (size),
        .offset    (offset),
        .data_in   (wdata),
        .lane_data (lane_data),
        .byte_en   (byte_en)
    );

    data_ram u_data_ram
    (
        .clk     (clk),
        .we      (ram_we),
        .byte_en (byte_en),
        .index   (index),
        .wdata   (lane_data),
        .rdata   (ram_rdata)
    );

    load_align u_load_align
    (
        .size      (rsp_size),
        .offset    (rsp_offset),
        .is_signed (rsp_signed),
        .word_in   (ram_rdata),
        .data_out  (load_data)
    );

endmodule : mem_stage_top

// ==== hdl/mem_ctrl.sv ====
`include "mem_stage_defines.svh"

module mem_ctrl
(
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req,
    input  logic                        is_store,
    input  logic [2:0]                  funct3,
    input  logic [`MEM_ADDR_W-1:0]      addr,
    output mem_stage_pkg::access_size_t size,
    output logic [1:0]                  offset,
    output logic                        ram_we,
    output logic [`MEM_RAM_AW-1:0]      index,
    output mem_stage_pkg::access_size_t rsp_size,
    output logic [1:0]                  rsp_offset,
    output logic                        rsp_signed,
    input  logic [`MEM_XLEN-1:0]        load_data,
    output logic                        resp,
    output logic                        fault,
    output logic [`MEM_XLEN-1:0]        rdata
);

    import mem_stage_pkg::*;

    logic code_ok;                                   // Funct3 names a real access.
    logic req_signed;                                // Load needs sign extension.
    logic misaligned;
    logic bad;                                       // Request must fault.
    logic load_ok_q;                                 // Previous request was a good load.

    always_comb
    begin
        size       = size_word;
        req_signed = 1'b0;
        code_ok    = 1'b1;
        if (is_store)
        begin
            case (store_funct3_t'(funct3))
                sb:      size = size_byte;
                sh:      size = size_half;
                sw:      size = size_word;
                default: code_ok = 1'b0;
            endcase
        end
        else
        begin
            case (load_funct3_t'(funct3))
                lb:
                begin
                    size       = size_byte;
                    req_signed = 1'b1;
                end
                lh:
                begin
                    size       = size_half;
                    req_signed = 1'b1;
                end
                lw:      size = size_word;
                lbu:     size = size_byte;
                lhu:     size = size_half;
                default: code_ok = 1'b0;
            endcase
        end
    end

    // Halfwords need an even address, words a multiple of four.
    assign misaligned = ((size == size_half) && addr[0]) ||
                        ((size == size_word) && (addr[1:0] != 2'b00));
    assign bad        = misaligned || !code_ok;

    assign offset = addr[1:0];
    assign index  = addr[`MEM_RAM_AW+1:2];           // Upper address bits alias.
    assign ram_we = req && is_store && !bad;         // A faulting store writes nothing.

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            resp      <= 1'b0;
            fault     <= 1'b0;
            load_ok_q <= 1'b0;
        end
        else
        begin
            resp      <= req;
            fault     <= req && bad;
            load_ok_q <= req && !is_store && !bad;
        end
    end

    // Held for load_align while the RAM read completes.
    always_ff @(posedge clk)
    begin
        if (req)
        begin
            rsp_size   <= size;
            rsp_offset <= addr[1:0];
            rsp_signed <= req_signed;
        end
    end

    assign rdata = load_ok_q ? load_data : '0;       // Stores and faults return zero.

endmodule : mem_ctrl

// ==== hdl/data_ram.sv ====
`include "mem_stage_defines.svh"

module data_ram
(
    input  logic                   clk,
    input  logic                   we,
    input  logic [`MEM_LANES-1:0]  byte_en,
    input  logic [`MEM_RAM_AW-1:0] index,
    input  logic [`MEM_XLEN-1:0]   wdata,
    output logic [`MEM_XLEN-1:0]   rdata
);

    localparam int DEPTH = 2 ** `MEM_RAM_AW;

    logic [`MEM_XLEN-1:0] mem [DEPTH];               // Word storage, filled by stores.

    // Byte-lane writes.
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            for (int i = 0; i < `MEM_LANES; i++)
            begin
                if (byte_en[i])
                    mem[index][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // Registered read. A write to the same word on this edge is not seen yet.
    always_ff @(posedge clk)
    begin
        rdata <= mem[index];
    end

endmodule : data_ram

// ==== hdl/load_align.sv ====
`include "mem_stage_defines.svh"

module load_align
(
    input  mem_stage_pkg::access_size_t size,
    input  logic [1:0]                  offset,
    input  logic                        is_signed,
    input  logic [`MEM_XLEN-1:0]        word_in,
    output logic [`MEM_XLEN-1:0]        data_out
);

    import mem_stage_pkg::*;

    logic [7:0]  byte_sel;                           // Byte picked by the offset.
    logic [15:0] half_sel;                           // Halfword picked by offset bit 1.

    always_comb
    begin
        case (offset)
            2'b00:   byte_sel = word_in[7:0];
            2'b01:   byte_sel = word_in[15:8];
            2'b10:   byte_sel = word_in[23:16];
            default: byte_sel = word_in[31:24];
        endcase
    end

    assign half_sel = offset[1] ? word_in[31:16] : word_in[15:0];

    always_comb
    begin
        case (size)
            size_byte:
            begin
                if (is_signed)
                    data_out = {{24{byte_sel[7]}}, byte_sel};   // Replicate the sign bit.
                else
                    data_out = {24'b0, byte_sel};
            end
            size_half:
            begin
                if (is_signed)
                    data_out = {{16{half_sel[15]}}, half_sel};
                else
                    data_out = {16'b0, half_sel};
            end
            default:
            begin
                data_out = word_in;                  // Words need no extension.
            end
        endcase
    end

endmodule : load_align

// ==== hdl/store_align.sv ====
`include "mem_stage_defines.svh"

module store_align
(
    input  mem_stage_pkg::access_size_t size,
    input  logic [1:0]                  offset,
    input  logic [`MEM_XLEN-1:0]        data_in,
    output logic [`MEM_XLEN-1:0]        lane_data,
    output logic [`MEM_LANES-1:0]       byte_en
);

    import mem_stage_pkg::*;

    always_comb
    begin
        lane_data = '0;                              // Unused lanes stay zero.
        byte_en   = '0;
        case (size)
            size_byte:
            begin
                case (offset)
                    2'b00:
                    begin
                        lane_data = {24'b0, data_in[7:0]};
                        byte_en   = 4'b0001;
                    end
                    2'b01:
                    begin
                        lane_data = {16'b0, data_in[7:0], 8'b0};
                        byte_en   = 4'b0010;
                    end
                    2'b10:
                    begin
                        lane_data = {8'b0, data_in[7:0], 16'b0};
                        byte_en   = 4'b0100;
                    end
                    default:
                    begin
                        lane_data = {data_in[7:0], 24'b0};
                        byte_en   = 4'b1000;
                    end
                endcase
            end
            size_half:
            begin
                if (offset[1])                       // Upper half of the word.
                begin
                    lane_data = {data_in[15:0], 16'b0};
                    byte_en   = 4'b1100;
                end
                else
                begin
                    lane_data = {16'b0, data_in[15:0]};
                    byte_en   = 4'b0011;
                end
            end
            default:
            begin
                lane_data = data_in;                 // A word fills all lanes.
                byte_en   = 4'b1111;
            end
        endcase
    end

endmodule : store_align

// ==== hdl/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // Store codes as carried in funct3 of an RV32I store.
    typedef enum logic [2:0]
    {
        sb = 3'd0,  // Store byte.
        sh = 3'd1,  // Store halfword.
        sw = 3'd2   // Store word.
    } store_funct3_t;

    // Load codes as carried in funct3 of an RV32I load.
    typedef enum logic [2:0]
    {
        lb  = 3'd0, // Load byte, sign-extended.
        lh  = 3'd1, // Load halfword, sign-extended.
        lw  = 3'd2, // Load word.
        lbu = 3'd4, // Load byte, zero-extended.
        lhu = 3'd5  // Load halfword, zero-extended.
    } load_funct3_t;

    // Access width shared by the control block and both align blocks.
    typedef enum logic [1:0]
    {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

endpackage : mem_stage_pkg

// ==== hdl/mem_stage_defines.svh ====
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// Width of a data word in bits.
`define MEM_XLEN 32

// Width of the byte address carried on the request ports.
`define MEM_ADDR_W 32

// Log2 of the RAM depth in words. Any value from 4 to 12 works.
// Address bits above the RAM index are ignored, so the memory aliases.
`define MEM_RAM_AW 8

// Byte lanes per data word.
`define MEM_LANES (`MEM_XLEN / 8)

`endif
